// ==== rtl/pcs_err_pkg.sv ====
package pcs_err_pkg;

        // 64b/66b block layout, sync header in the top two bits
        localparam int NB_CODED_BLOCK = 66;
        localparam int NB_PAYLOAD     = 64;
        localparam int NB_SH          = 2;

        localparam logic [NB_SH-1:0] SH_DATA = 2'b01;
        localparam logic [NB_SH-1:0] SH_CTRL = 2'b10;

        // one-hot block selection modes
        localparam int N_MODES = 4;

        localparam logic [N_MODES-1:0] MODE_ALIN = 4'b0001;
        localparam logic [N_MODES-1:0] MODE_CTRL = 4'b0010;
        localparam logic [N_MODES-1:0] MODE_DATA = 4'b0100;
        localparam logic [N_MODES-1:0] MODE_ALL  = 4'b1000;

        // bit positions in the target field
        localparam int TGT_SH      = 0;
        localparam int TGT_PAYLOAD = 1;

        localparam int NB_BYTE       = 8;
        localparam int N_DATA_BYTES  = NB_PAYLOAD / NB_BYTE;
        localparam int NB_BLOCK_TYPE = 8;
        localparam int NB_CTRL_BODY  = NB_PAYLOAD - NB_BLOCK_TYPE;

        // control block, block type sits in the upper byte
        typedef struct packed
        {
                logic [NB_BLOCK_TYPE-1:0] block_type;
                logic [NB_CTRL_BODY-1:0]  body;
        } ctrl_view_t;

        // payload seen either as plain data or as a control block
        typedef union packed
        {
                logic [N_DATA_BYTES-1:0][NB_BYTE-1:0] bytes;
                ctrl_view_t                           ctrl;
        } payload_u;

endpackage

// ==== rtl/err_inject_regs.sv ====
`timescale 1ns/1ps

module err_inject_regs
#(
        parameter  MAX_ERR_BURST  = 200,
        parameter  MAX_ERR_PERIOD = 400,
        parameter  MAX_ERR_REPEAT = 100,
        localparam NB_BURST_CNT   = $clog2(MAX_ERR_BURST),
        localparam NB_PERIOD_CNT  = $clog2(MAX_ERR_PERIOD),
        localparam NB_REPEAT_CNT  = $clog2(MAX_ERR_REPEAT)
)
(
        input  logic                                i_clock,
        input  logic                                i_rst_n,
        input  logic                                i_rf_update,
        input  logic [pcs_err_pkg::N_MODES-1:0]     i_rf_mode,
        input  logic [1:0]                          i_rf_target,
        input  logic [pcs_err_pkg::NB_PAYLOAD-1:0]  i_rf_error_mask,
        input  logic [NB_BURST_CNT-1:0]             i_rf_error_burst,
        input  logic [NB_PERIOD_CNT-1:0]            i_rf_error_period,
        input  logic [NB_REPEAT_CNT-1:0]            i_rf_error_repeat,

        output logic [pcs_err_pkg::N_MODES-1:0]     o_mode,
        output logic [1:0]                          o_target,
        output logic [pcs_err_pkg::NB_PAYLOAD-1:0]  o_mask,
        output logic [NB_BURST_CNT-1:0]             o_burst,
        output logic [NB_PERIOD_CNT-1:0]            o_period,
        output logic [NB_REPEAT_CNT-1:0]            o_repeat,
        output logic                                o_restart
);

// whole set is loaded on one edge
always_ff @(posedge i_clock)
begin
        if (!i_rst_n)
        begin
                o_mode   <= '0;
                o_target <= '0;
                o_mask   <= '0;
                o_burst  <= '0;
                o_period <= '0;
                o_repeat <= '0;
        end
        else if (i_rf_update)
        begin
                o_mode   <= i_rf_mode;
                o_target <= i_rf_target;
                o_mask   <= i_rf_error_mask;
                o_burst  <= i_rf_error_burst;
                o_period <= i_rf_error_period;
                o_repeat <= i_rf_error_repeat;
        end
end

// one cycle pulse right after the load
always_ff @(posedge i_clock)
begin
        if (!i_rst_n)
        begin
                o_restart <= 1'b0;
        end
        else
        begin
                o_restart <= i_rf_update;
        end
end

endmodule

// ==== rtl/err_burst_sched.sv ====
`timescale 1ns/1ps

module err_burst_sched
#(
        parameter  MAX_ERR_BURST  = 200,
        parameter  MAX_ERR_PERIOD = 400,
        parameter  MAX_ERR_REPEAT = 100,
        localparam NB_BURST_CNT   = $clog2(MAX_ERR_BURST),
        localparam NB_PERIOD_CNT  = $clog2(MAX_ERR_PERIOD),
        localparam NB_REPEAT_CNT  = $clog2(MAX_ERR_REPEAT)
)
(
        input  logic                                    i_clock,
        input  logic                                    i_rst_n,
        input  logic                                    i_valid,
        input  logic                                    i_aligner_tag,
        input  logic [pcs_err_pkg::NB_CODED_BLOCK-1:0]  i_data,
        input  logic [pcs_err_pkg::N_MODES-1:0]         i_mode,
        input  logic [NB_BURST_CNT-1:0]                 i_burst,
        input  logic [NB_PERIOD_CNT-1:0]                i_period,
        input  logic [NB_REPEAT_CNT-1:0]                i_repeat,
        input  logic                                    i_restart,

        output logic                                    o_valid,
        output logic                                    o_aligner_tag,
        output logic [pcs_err_pkg::NB_CODED_BLOCK-1:0]  o_data,
        output logic                                    o_hit
);

localparam NB_CMP = (NB_PERIOD_CNT > NB_BURST_CNT) ? NB_PERIOD_CNT : NB_BURST_CNT;

logic [pcs_err_pkg::NB_SH-1:0]   sh;
logic [pcs_err_pkg::N_MODES-1:0] match;
logic                            eligible;
logic                            armed;
logic                            in_burst;
logic [NB_PERIOD_CNT-1:0]        period_cnt;
logic [NB_REPEAT_CNT-1:0]        repeat_cnt;
logic [NB_CMP-1:0]               idx_ext;
logic [NB_CMP-1:0]               burst_ext;

assign sh = i_data[pcs_err_pkg::NB_PAYLOAD +: pcs_err_pkg::NB_SH];

// mode bits this block would satisfy
assign match = (i_aligner_tag ? pcs_err_pkg::MODE_ALIN : '0)
             | ((sh == pcs_err_pkg::SH_CTRL) ? pcs_err_pkg::MODE_CTRL : '0)
             | ((sh == pcs_err_pkg::SH_DATA) ? pcs_err_pkg::MODE_DATA : '0)
             | pcs_err_pkg::MODE_ALL;

// blocks arriving with the restart pulse see neither old nor new schedule
assign eligible = i_valid && !i_restart && (|(i_mode & match));

// schedule still running: nonzero period and repeats left
assign armed = (i_period != '0) && (repeat_cnt < i_repeat);

assign idx_ext   = NB_CMP'(period_cnt);
assign burst_ext = NB_CMP'(i_burst);
assign in_burst  = idx_ext < burst_ext;

always_ff @(posedge i_clock)
begin
        if (!i_rst_n || i_restart)
        begin
                period_cnt <= '0;
                repeat_cnt <= '0;
        end
        else if (eligible && armed)
        begin
                if (period_cnt == i_period - 1'b1)
                begin
                        period_cnt <= '0;
                        repeat_cnt <= repeat_cnt + 1'b1;
                end
                else
                begin
                        period_cnt <= period_cnt + 1'b1;
                end
        end
end

always_ff @(posedge i_clock)
begin
        if (!i_rst_n)
        begin
                o_valid <= 1'b0;
                o_hit   <= 1'b0;
        end
        else
        begin
                o_valid <= i_valid;
                o_hit   <= eligible && armed && in_burst;
        end
end

always_ff @(posedge i_clock)
begin
        o_aligner_tag <= i_aligner_tag;
        o_data        <= i_data;
end

endmodule

// ==== rtl/sh_breaker.sv ====
`timescale 1ns/1ps

module sh_breaker
(
        input  logic                                    i_clock,
        input  logic                                    i_rst_n,
        input  logic                                    i_valid,
        input  logic                                    i_aligner_tag,
        input  logic [pcs_err_pkg::NB_CODED_BLOCK-1:0]  i_data,
        input  logic                                    i_hit,
        input  logic                                    i_sh_en,

        output logic                                    o_valid,
        output logic                                    o_aligner_tag,
        output logic [pcs_err_pkg::NB_CODED_BLOCK-1:0]  o_data,
        output logic                                    o_hit,
        output logic                                    o_corrupted
);

logic                          break_sh;
logic [pcs_err_pkg::NB_SH-1:0] sh_in;
logic [pcs_err_pkg::NB_SH-1:0] sh_out;

assign break_sh = i_hit && i_sh_en;
assign sh_in    = i_data[pcs_err_pkg::NB_PAYLOAD +: pcs_err_pkg::NB_SH];

// 01 -> 00, 10 -> 11; bit 1 keeps the original block kind
assign sh_out = break_sh ? {sh_in[1], ~sh_in[0]} : sh_in;

always_ff @(posedge i_clock)
begin
        if (!i_rst_n)
        begin
                o_valid     <= 1'b0;
                o_hit       <= 1'b0;
                o_corrupted <= 1'b0;
        end
        else
        begin
                o_valid     <= i_valid;
                o_hit       <= i_hit;
                o_corrupted <= break_sh;
        end
end

always_ff @(posedge i_clock)
begin
        o_aligner_tag <= i_aligner_tag;
        o_data        <= {sh_out, i_data[pcs_err_pkg::NB_PAYLOAD-1:0]};
end

endmodule

// ==== rtl/payload_breaker.sv ====
`timescale 1ns/1ps

module payload_breaker
(
        input  logic                                    i_clock,
        input  logic                                    i_rst_n,
        input  logic                                    i_valid,
        input  logic                                    i_aligner_tag,
        input  logic [pcs_err_pkg::NB_CODED_BLOCK-1:0]  i_data,
        input  logic                                    i_hit,
        input  logic                                    i_corrupted,
        input  logic                                    i_payload_en,
        input  logic [pcs_err_pkg::NB_PAYLOAD-1:0]      i_mask,

        output logic                                    o_valid,
        output logic                                    o_aligner_tag,
        output logic [pcs_err_pkg::NB_CODED_BLOCK-1:0]  o_data,
        output logic                                    o_err_hit
);

logic                          break_pl;
logic [pcs_err_pkg::NB_SH-1:0] sh_in;
logic [pcs_err_pkg::NB_SH-1:0] sh_orig;
pcs_err_pkg::payload_u         pl_in;
pcs_err_pkg::payload_u         pl_mask;
pcs_err_pkg::payload_u         pl_out;

assign break_pl = i_hit && i_payload_en;
assign sh_in    = i_data[pcs_err_pkg::NB_PAYLOAD +: pcs_err_pkg::NB_SH];
assign pl_in    = i_data[pcs_err_pkg::NB_PAYLOAD-1:0];
assign pl_mask  = i_mask;

// undo the previous stage's inversion to recover the block kind
assign sh_orig = i_corrupted ? {sh_in[1], ~sh_in[0]} : sh_in;

always_comb
begin
        pl_out = pl_in;
        if (break_pl)
        begin
                if (sh_orig == pcs_err_pkg::SH_DATA)
                begin
                        for (int i = 0; i < pcs_err_pkg::N_DATA_BYTES; i++)
                        begin
                                pl_out.bytes[i] = pl_in.bytes[i] ^ pl_mask.bytes[i];
                        end
                end
                else
                begin
                        // block type byte stays intact
                        pl_out.ctrl.body = pl_in.ctrl.body ^ pl_mask.ctrl.body;
                end
        end
end

always_ff @(posedge i_clock)
begin
        if (!i_rst_n)
        begin
                o_valid   <= 1'b0;
                o_err_hit <= 1'b0;
        end
        else
        begin
                o_valid   <= i_valid;
                o_err_hit <= i_corrupted || break_pl;
        end
end

always_ff @(posedge i_clock)
begin
        o_aligner_tag <= i_aligner_tag;
        o_data        <= {sh_in, pl_out};
end

endmodule

// ==== rtl/err_inject_top.sv ====
`timescale 1ns/1ps

module err_inject_top
#(
        parameter  MAX_ERR_BURST  = 200,
        parameter  MAX_ERR_PERIOD = 400,
        parameter  MAX_ERR_REPEAT = 100,
        localparam NB_BURST_CNT   = $clog2(MAX_ERR_BURST),
        localparam NB_PERIOD_CNT  = $clog2(MAX_ERR_PERIOD),
        localparam NB_REPEAT_CNT  = $clog2(MAX_ERR_REPEAT)
)
(
        input  logic                                    i_clock,
        input  logic                                    i_rst_n,
        input  logic                                    i_valid,
        input  logic                                    i_aligner_tag,
        input  logic [pcs_err_pkg::NB_CODED_BLOCK-1:0]  i_data,
        input  logic                                    i_rf_update,
        input  logic [pcs_err_pkg::N_MODES-1:0]         i_rf_mode,
        input  logic [1:0]                              i_rf_target,
        input  logic [pcs_err_pkg::NB_PAYLOAD-1:0]      i_rf_error_mask,
        input  logic [NB_BURST_CNT-1:0]                 i_rf_error_burst,
        input  logic [NB_PERIOD_CNT-1:0]                i_rf_error_period,
        input  logic [NB_REPEAT_CNT-1:0]                i_rf_error_repeat,

        output logic                                    o_valid,
        output logic                                    o_aligner_tag,
        output logic [pcs_err_pkg::NB_CODED_BLOCK-1:0]  o_data,
        output logic                                    o_err_hit
);

logic [pcs_err_pkg::N_MODES-1:0]        cfg_mode;
logic [1:0]                             cfg_target;
logic [pcs_err_pkg::NB_PAYLOAD-1:0]     cfg_mask;
logic [NB_BURST_CNT-1:0]                cfg_burst;
logic [NB_PERIOD_CNT-1:0]               cfg_period;
logic [NB_REPEAT_CNT-1:0]               cfg_repeat;
logic                                   restart;

logic                                   s1_valid;
logic                                   s1_tag;
logic [pcs_err_pkg::NB_CODED_BLOCK-1:0] s1_data;
logic                                   s1_hit;

logic                                   s2_valid;
logic                                   s2_tag;
logic [pcs_err_pkg::NB_CODED_BLOCK-1:0] s2_data;
logic                                   s2_hit;
logic                                   s2_corrupted;

err_inject_regs
#(
        .MAX_ERR_BURST  (MAX_ERR_BURST),
        .MAX_ERR_PERIOD (MAX_ERR_PERIOD),
        .MAX_ERR_REPEAT (MAX_ERR_REPEAT)
)
        u_err_inject_regs
        (
                .i_clock                (i_clock),
                .i_rst_n                (i_rst_n),
                .i_rf_update            (i_rf_update),
                .i_rf_mode              (i_rf_mode),
                .i_rf_target            (i_rf_target),
                .i_rf_error_mask        (i_rf_error_mask),
                .i_rf_error_burst       (i_rf_error_burst),
                .i_rf_error_period      (i_rf_error_period),
                .i_rf_error_repeat      (i_rf_error_repeat),
                .o_mode                 (cfg_mode),
                .o_target               (cfg_target),
                .o_mask                 (cfg_mask),
                .o_burst                (cfg_burst),
                .o_period               (cfg_period),
                .o_repeat               (cfg_repeat),
                .o_restart              (restart)
        );

err_burst_sched
#(
        .MAX_ERR_BURST  (MAX_ERR_BURST),
        .MAX_ERR_PERIOD (MAX_ERR_PERIOD),
        .MAX_ERR_REPEAT (MAX_ERR_REPEAT)
)
        u_err_burst_sched
        (
                .i_clock                (i_clock),
                .i_rst_n                (i_rst_n),
                .i_valid                (i_valid),
                .i_aligner_tag          (i_aligner_tag),
                .i_data                 (i_data),
                .i_mode                 (cfg_mode),
                .i_burst                (cfg_burst),
                .i_period               (cfg_period),
                .i_repeat               (cfg_repeat),
                .i_restart              (restart),
                .o_valid                (s1_valid),
                .o_aligner_tag          (s1_tag),
                .o_data                 (s1_data),
                .o_hit                  (s1_hit)
        );

sh_breaker
        u_sh_breaker
        (
                .i_clock                (i_clock),
                .i_rst_n                (i_rst_n),
                .i_valid                (s1_valid),
                .i_aligner_tag          (s1_tag),
                .i_data                 (s1_data),
                .i_hit                  (s1_hit),
                .i_sh_en                (cfg_target[pcs_err_pkg::TGT_SH]),
                .o_valid                (s2_valid),
                .o_aligner_tag          (s2_tag),
                .o_data                 (s2_data),
                .o_hit                  (s2_hit),
                .o_corrupted            (s2_corrupted)
        );

payload_breaker
        u_payload_breaker
        (
                .i_clock                (i_clock),
                .i_rst_n                (i_rst_n),
                .i_valid                (s2_valid),
                .i_aligner_tag          (s2_tag),
                .i_data                 (s2_data),
                .i_hit                  (s2_hit),
                .i_corrupted            (s2_corrupted),
                .i_payload_en           (cfg_target[pcs_err_pkg::TGT_PAYLOAD]),
                .i_mask                 (cfg_mask),
                .o_valid                (o_valid),
                .o_aligner_tag          (o_aligner_tag),
                .o_data                 (o_data),
                .o_err_hit              (o_err_hit)
        );

endmodule

// ==== tests/err_inject_sva.sv ====
`timescale 1ns/1ps

module err_inject_sva
(
        input logic i_clock,
        input logic i_rst_n,
        input logic i_valid,
        input logic o_valid,
        input logic o_err_hit
);

// output strobe cleared by reset
a_valid_in_reset: assert property (@(posedge i_clock) !i_rst_n |=> !o_valid)
        else $error("o_valid high after a reset cycle");

a_hit_needs_valid: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_err_hit |-> o_valid)
        else $error("o_err_hit high on a bubble");

// three register stages, bubbles kept in place
a_valid_latency: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_valid == $past(i_valid, 3))
        else $error("o_valid does not follow i_valid by three cycles");

endmodule

bind err_inject_top err_inject_sva u_err_inject_sva
(
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_valid   (i_valid),
        .o_valid   (o_valid),
        .o_err_hit (o_err_hit)
);

// ==== tests/tb_err_inject.sv ====
`timescale 1ns/1ps

module tb_err_inject;

localparam int MAX_ERR_BURST  = 200;
localparam int MAX_ERR_PERIOD = 400;
localparam int MAX_ERR_REPEAT = 100;
localparam int NB_BURST_CNT   = $clog2(MAX_ERR_BURST);
localparam int NB_PERIOD_CNT  = $clog2(MAX_ERR_PERIOD);
localparam int NB_REPEAT_CNT  = $clog2(MAX_ERR_REPEAT);
localparam int NB_BLK         = pcs_err_pkg::NB_CODED_BLOCK;
localparam int NB_PL          = pcs_err_pkg::NB_PAYLOAD;
localparam int DRAIN_LIMIT    = 50;

logic                     i_clock = 1'b0;
logic                     i_rst_n;
logic                     i_valid;
logic                     i_aligner_tag;
logic [NB_BLK-1:0]        i_data;
logic                     i_rf_update;
logic [3:0]               i_rf_mode;
logic [1:0]               i_rf_target;
logic [NB_PL-1:0]         i_rf_error_mask;
logic [NB_BURST_CNT-1:0]  i_rf_error_burst;
logic [NB_PERIOD_CNT-1:0] i_rf_error_period;
logic [NB_REPEAT_CNT-1:0] i_rf_error_repeat;
logic                     o_valid;
logic                     o_aligner_tag;
logic [NB_BLK-1:0]        o_data;
logic                     o_err_hit;

// reference model configuration and schedule state
logic [31:0]      rng = 32'd89707;
logic [3:0]       m_mode;
logic [1:0]       m_target;
logic [NB_PL-1:0] m_mask;
int               m_burst;
int               m_period;
int               m_repeat;
int               m_idx;
int               m_rep;

logic [NB_BLK-1:0] exp_data_q[$];
logic              exp_tag_q[$];
logic              exp_hit_q[$];
int                exp_cyc_q[$];

int                cyc = 0;
int                err_count = 0;
int                check_count = 0;
int                test_errs = 0;
int                obs_hits = 0;
logic [NB_BLK-1:0] mon_data;
logic              mon_tag;
logic              mon_hit;
int                mon_cyc;

err_inject_top
#(
        .MAX_ERR_BURST  (MAX_ERR_BURST),
        .MAX_ERR_PERIOD (MAX_ERR_PERIOD),
        .MAX_ERR_REPEAT (MAX_ERR_REPEAT)
)
        u_err_inject_top
        (
                .*
        );

always #10 i_clock = ~i_clock;

always @(posedge i_clock)
begin
        cyc <= cyc + 1;
end

function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
endfunction

task automatic check(input string name, input logic [NB_BLK-1:0] got,
                     input logic [NB_BLK-1:0] exp);
        check_count++;
        if (got !== exp)
        begin
                err_count++;
                $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
endtask

// expected block after the schedule and corruption rules
task model_block(input logic tag, input logic [NB_BLK-1:0] blk);
        logic [1:0]        sh;
        logic              elig;
        logic              hit;
        logic [NB_BLK-1:0] exp;
        sh   = blk[NB_PL +: 2];
        elig = (|(m_mode & pcs_err_pkg::MODE_ALIN) && tag)
            || (|(m_mode & pcs_err_pkg::MODE_CTRL) && sh == pcs_err_pkg::SH_CTRL)
            || (|(m_mode & pcs_err_pkg::MODE_DATA) && sh == pcs_err_pkg::SH_DATA)
            || |(m_mode & pcs_err_pkg::MODE_ALL);
        hit  = 1'b0;
        if (elig && m_period != 0 && m_rep < m_repeat)
        begin
                hit = (m_idx < m_burst);
                if (m_idx == m_period - 1)
                begin
                        m_idx = 0;
                        m_rep++;
                end
                else
                begin
                        m_idx++;
                end
        end
        exp = blk;
        if (hit && m_target[pcs_err_pkg::TGT_SH])
        begin
                exp[NB_PL] = ~exp[NB_PL];
        end
        if (hit && m_target[pcs_err_pkg::TGT_PAYLOAD])
        begin
                if (sh == pcs_err_pkg::SH_DATA)
                begin
                        exp[NB_PL-1:0] = exp[NB_PL-1:0] ^ m_mask;
                end
                else
                begin
                        exp[55:0] = exp[55:0] ^ m_mask[55:0];
                end
        end
        exp_data_q.push_back(exp);
        exp_tag_q.push_back(tag);
        exp_hit_q.push_back(hit && m_target != 2'b00);
        exp_cyc_q.push_back(cyc);
endtask

task drive_block(input logic v, input logic tag, input logic [NB_BLK-1:0] blk);
        @(negedge i_clock);
        i_valid       = v;
        i_aligner_tag = tag;
        i_data        = blk;
        if (v)
        begin
                model_block(tag, blk);
        end
endtask

// random headers, tags and payloads, optionally with bubbles
task send_random(input int n, input bit bubbles);
        logic              v;
        logic              tag;
        logic [NB_BLK-1:0] blk;
        for (int k = 0; k < n; k++)
        begin
                rng = next_rand(rng);
                v   = !(bubbles && rng[2:0] == 3'd0);
                tag = (rng[4:3] == 2'd0);
                blk[NB_PL +: 2] = rng[5] ? pcs_err_pkg::SH_CTRL : pcs_err_pkg::SH_DATA;
                rng = next_rand(rng);
                blk[63:32] = rng;
                rng = next_rand(rng);
                blk[31:0] = rng;
                drive_block(v, tag, blk);
        end
        drive_block(1'b0, 1'b0, '0);
endtask

task drain;
        int waited;
        waited = 0;
        while (exp_data_q.size() != 0 && waited < DRAIN_LIMIT)
        begin
                @(negedge i_clock);
                waited++;
        end
        if (exp_data_q.size() != 0)
        begin
                err_count++;
                $display("Timeout at %0t: %0d expected blocks never came out",
                         $time, exp_data_q.size());
                exp_data_q.delete();
                exp_tag_q.delete();
                exp_hit_q.delete();
                exp_cyc_q.delete();
        end
endtask

task write_config(input logic [3:0] mode, input logic [1:0] target,
                  input logic [NB_PL-1:0] mask, input int burst, input int period,
                  input int rpt);
        drain();
        @(negedge i_clock);
        i_rf_update       = 1'b1;
        i_rf_mode         = mode;
        i_rf_target       = target;
        i_rf_error_mask   = mask;
        i_rf_error_burst  = burst[NB_BURST_CNT-1:0];
        i_rf_error_period = period[NB_PERIOD_CNT-1:0];
        i_rf_error_repeat = rpt[NB_REPEAT_CNT-1:0];
        @(negedge i_clock);
        i_rf_update = 1'b0;
        m_mode      = mode;
        m_target    = target;
        m_mask      = mask;
        m_burst     = burst;
        m_period    = period;
        m_repeat    = rpt;
        m_idx       = 0;
        m_rep       = 0;
        obs_hits    = 0;
        repeat (2) @(negedge i_clock);
endtask

task end_test(input string name);
        drain();
        $display("test %s finished with %0d errors", name, err_count - test_errs);
        test_errs = err_count;
endtask

task test_reset_passthrough;
        send_random(40, 1'b1);
        end_test("reset passthrough");
endtask

task test_all_burst;
        rng = next_rand(rng);
        write_config(pcs_err_pkg::MODE_ALL, 2'b11, {rng, ~rng}, 3, 5, 2);
        send_random(16, 1'b0);
        drain();
        check("o_err_hit count", NB_BLK'(obs_hits), NB_BLK'(6));
        end_test("all blocks burst");
endtask

task test_ctrl_payload;
        rng = next_rand(rng);
        write_config(pcs_err_pkg::MODE_CTRL, 2'b10, {~rng, rng}, 2, 4, 3);
        send_random(30, 1'b1);
        end_test("control payload");
endtask

task test_alin_header;
        rng = next_rand(rng);
        write_config(pcs_err_pkg::MODE_ALIN, 2'b01, {~rng, rng}, 1, 3, 3);
        send_random(40, 1'b1);
        end_test("aligner header");
endtask

task test_repeat_restart;
        rng = next_rand(rng);
        write_config(pcs_err_pkg::MODE_ALL, 2'b11, {rng, rng}, 2, 3, 1);
        send_random(10, 1'b0);
        drain();
        check("o_err_hit count", NB_BLK'(obs_hits), NB_BLK'(2));
        // burst above period, so the whole schedule hits
        write_config(pcs_err_pkg::MODE_ALL, 2'b11, {rng, ~rng}, 6, 4, 3);
        send_random(16, 1'b0);
        drain();
        check("o_err_hit count", NB_BLK'(obs_hits), NB_BLK'(12));
        end_test("repeat and restart");
endtask

task test_no_corruption;
        write_config(pcs_err_pkg::MODE_ALL, 2'b11, '1, 3, 0, 5);
        send_random(20, 1'b1);
        drain();
        check("o_err_hit count", NB_BLK'(obs_hits), '0);
        write_config(4'b0000, 2'b11, '1, 4, 4, 5);
        send_random(20, 1'b1);
        drain();
        check("o_err_hit count", NB_BLK'(obs_hits), '0);
        end_test("no corruption");
endtask

// outputs are registered on the rising edge and stable here
always @(negedge i_clock)
begin
        if (o_valid)
        begin
                if (o_err_hit === 1'b1)
                begin
                        obs_hits++;
                end
                if (exp_data_q.size() == 0)
                begin
                        err_count++;
                        $display("Error at %0t: output block with no block sent", $time);
                end
                else
                begin
                        mon_data = exp_data_q.pop_front();
                        mon_tag  = exp_tag_q.pop_front();
                        mon_hit  = exp_hit_q.pop_front();
                        mon_cyc  = exp_cyc_q.pop_front();
                        check("latency", NB_BLK'(cyc - mon_cyc), NB_BLK'(3));
                        check("o_data", o_data, mon_data);
                        check("o_aligner_tag", NB_BLK'(o_aligner_tag), NB_BLK'(mon_tag));
                        check("o_err_hit", NB_BLK'(o_err_hit), NB_BLK'(mon_hit));
                end
        end
        else
        begin
                check("o_err_hit", NB_BLK'(o_err_hit), '0);
        end
end

initial
begin
        i_rst_n           = 1'b0;
        i_valid           = 1'b0;
        i_aligner_tag     = 1'b0;
        i_data            = '0;
        i_rf_update       = 1'b0;
        i_rf_mode         = '0;
        i_rf_target       = '0;
        i_rf_error_mask   = '0;
        i_rf_error_burst  = '0;
        i_rf_error_period = '0;
        i_rf_error_repeat = '0;
        m_mode            = '0;
        m_target          = '0;
        m_mask            = '0;
        m_burst           = 0;
        m_period          = 0;
        m_repeat          = 0;
        m_idx             = 0;
        m_rep             = 0;
        repeat (4) @(negedge i_clock);
        i_rst_n = 1'b1;
        test_reset_passthrough();
        test_all_burst();
        test_ctrl_payload();
        test_alin_header();
        test_repeat_restart();
        test_no_corruption();
        $display("%0d checks, %0d errors", check_count, err_count);
        if (err_count == 0)
        begin
                $display("sim passed");
        end
        else
        begin
                $display("sim failed");
        end
        $finish;
end

endmodule

// ==== flist.f ====
rtl/pcs_err_pkg.sv
rtl/err_inject_regs.sv
rtl/err_burst_sched.sv
rtl/sh_breaker.sv
rtl/payload_breaker.sv
rtl/err_inject_top.sv
tests/err_inject_sva.sv
tests/tb_err_inject.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_err_inject -o sim_tb \
        || { echo "run.sh: build error"; exit 1; }

out="$(./obj_dir/sim_tb 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "sim passed" \
        && echo "run.sh: PASS" \
        || { echo "run.sh: FAIL"; exit 1; }
